// ==== input_board.f ====
verilog/input_pkg.sv
verilog/joy_4way_filter.sv
verilog/joy_map_stage.sv
verilog/board_ctrl.sv
verilog/input_board.sv
test/input_board_chk.sv
test/input_board_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the input board testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f input_board.f \
    --top-module input_board_tb -o input_board_sim

./obj_dir/input_board_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== test/input_board_chk.sv ====
/*
 * concurrent assertions on the input board
 * soft reset pulse width, control outputs after reset
 */
module input_board_chk (
    input logic                        clk_sys,
    input logic                        rst,
    input logic                        soft_rst,
    input logic                        game_pause,
    input logic [input_pkg::GFX_W-1:0] gfx_en
);

    // a soft reset request is a single-cycle pulse
    soft_rst_single: assert property (
        @(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst
    ) else $error("soft_rst high for two cycles in a row");

    // all layers visible out of reset
    gfx_after_rst: assert property (
        @(posedge clk_sys) rst |=> (gfx_en == '1)
    ) else $error("gfx_en not all ones after reset");

    pause_after_rst: assert property (
        @(posedge clk_sys) rst |=> (!game_pause && !soft_rst)
    ) else $error("game_pause or soft_rst high after reset");

endmodule

// ==== test/input_board_tb.sv ====
/*
 * testbench for the input board
 * stimulus table and random rows for rotation, inversion and 4-way filter
 * pause, soft reset, layer enable and service checks
 */
module input_board_tb;

    localparam int NROWS = 8;
    localparam int NRAND = 8;

    // index 0 is player 1, so literals list player 4 first
    typedef struct packed {
        logic [3:0][15:0] joy;
        logic             en4way;
        logic             rot;
        logic             flip;
        logic [3:0][9:0]  exp_joy;
        logic [3:0]       exp_coin;
        logic [3:0]       exp_start;
    } row_t;

    logic        clk_sys;
    logic        rst;
    logic [15:0] board_joy1;
    logic [15:0] board_joy2;
    logic [15:0] board_joy3;
    logic [15:0] board_joy4;
    logic        en4way;
    logic        rot_control;
    logic        dip_flip;
    logic        downloading;
    logic        osd_pause;
    logic        key_pause;
    logic        key_reset;
    logic        key_service;
    logic [3:0]  key_gfx;
    logic [9:0]  game_joy1;
    logic [9:0]  game_joy2;
    logic [9:0]  game_joy3;
    logic [9:0]  game_joy4;
    logic [3:0]  game_coin;
    logic [3:0]  game_start;
    logic        game_service;
    logic        game_pause;
    logic        soft_rst;
    logic [3:0]  gfx_en;

    row_t        rows [NROWS];
    int          checks;
    int          errors;
    int          timeouts;
    int          seed;

    input_board #(
        .BUTTONS    (2),
        .ACTIVE_LOW (1'b1)
    ) DUT (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .board_joy1   (board_joy1),
        .board_joy2   (board_joy2),
        .board_joy3   (board_joy3),
        .board_joy4   (board_joy4),
        .en4way       (en4way),
        .rot_control  (rot_control),
        .dip_flip     (dip_flip),
        .downloading  (downloading),
        .osd_pause    (osd_pause),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .game_joy1    (game_joy1),
        .game_joy2    (game_joy2),
        .game_joy3    (game_joy3),
        .game_joy4    (game_joy4),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en)
    );

    bind input_board input_board_chk u_chk (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .soft_rst   (soft_rst),
        .game_pause (game_pause),
        .gfx_en     (gfx_en)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clk_sys);
        end
    endtask

    // outputs are read in the middle of the cycle
    task automatic settle(input int n);
        wait_cycles(n);
        @(negedge clk_sys);
    endtask

    task automatic wait_pause(input logic level, input string what);
        int n;
        n = 0;
        while (game_pause !== level && n < 20) begin
            @(negedge clk_sys);
            n++;
        end
        if (game_pause !== level) begin
            timeouts++;
            $display("timeout: game_pause never became %0b after %s", level, what);
        end
    endtask

    // direction remap per the rotation table, then active-low
    function automatic logic [9:0] expect_joy(input logic [15:0] word, input logic rot,
                                              input logic flip);
        logic [3:0] d;
        logic [3:0] m;
        d = word[3:0];
        case ({rot, flip})
            2'b10:   m = {d[1], d[0], d[2], d[3]};
            2'b11:   m = {d[0], d[1], d[3], d[2]};
            default: m = d;
        endcase
        return ~{word[9:4], m};
    endfunction

    task automatic load_table();
        // rot 0 passes directions with coin on p2 and start on p3
        rows[0] = '{{16'h0000, 16'h0040, 16'h0082, 16'h0001}, 1'b0, 1'b0, 1'b0,
                    {10'h3FF, 10'h3BF, 10'h37D, 10'h3FE}, 4'hD, 4'hB};
        rows[1] = '{{16'h0008, 16'h0004, 16'h0002, 16'h0001}, 1'b0, 1'b1, 1'b0,
                    {10'h3FE, 10'h3FD, 10'h3F7, 10'h3FB}, 4'hF, 4'hF};
        rows[2] = '{{16'h0008, 16'h0004, 16'h0002, 16'h0031}, 1'b0, 1'b1, 1'b1,
                    {10'h3FD, 10'h3FE, 10'h3FB, 10'h3C7}, 4'hF, 4'hF};
        rows[3] = '{{16'h0000, 16'h0000, 16'h0000, 16'h00C3}, 1'b0, 1'b0, 1'b1,
                    {10'h3FF, 10'h3FF, 10'h3FF, 10'h33C}, 4'hE, 4'hE};
        // 4-way rows where a single passes and diagonals hold
        rows[4] = '{{16'h0000, 16'h0000, 16'h0000, 16'h0004}, 1'b1, 1'b0, 1'b0,
                    {10'h3FF, 10'h3FF, 10'h3FF, 10'h3FB}, 4'hF, 4'hF};
        rows[5] = '{{16'h0000, 16'h0000, 16'h0003, 16'h0005}, 1'b1, 1'b0, 1'b0,
                    {10'h3FF, 10'h3FF, 10'h3FF, 10'h3FB}, 4'hF, 4'hF};
        rows[6] = '{{16'h0000, 16'h0000, 16'h0003, 16'h0005}, 1'b0, 1'b0, 1'b0,
                    {10'h3FF, 10'h3FF, 10'h3FC, 10'h3FA}, 4'hF, 4'hF};
        rows[7] = '{{16'h0000, 16'h0000, 16'h0003, 16'h0000}, 1'b1, 1'b0, 1'b0,
                    {10'h3FF, 10'h3FF, 10'h3FC, 10'h3FF}, 4'hF, 4'hF};
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_sys);
        board_joy1  <= r.joy[0];
        board_joy2  <= r.joy[1];
        board_joy3  <= r.joy[2];
        board_joy4  <= r.joy[3];
        en4way      <= r.en4way;
        rot_control <= r.rot;
        dip_flip    <= r.flip;
    endtask

    task automatic compare_row(input row_t r, input string tag);
        check(32'(game_joy1), 32'(r.exp_joy[0]), {tag, " game_joy1"});
        check(32'(game_joy2), 32'(r.exp_joy[1]), {tag, " game_joy2"});
        check(32'(game_joy3), 32'(r.exp_joy[2]), {tag, " game_joy3"});
        check(32'(game_joy4), 32'(r.exp_joy[3]), {tag, " game_joy4"});
        check(32'(game_coin), 32'(r.exp_coin), {tag, " game_coin"});
        check(32'(game_start), 32'(r.exp_start), {tag, " game_start"});
    endtask

    initial begin
        row_t        r;
        logic [31:0] rnd;
        int          i;
        int          p;
        int          pulses;

        rst         = 1'b1;
        board_joy1  = '0;
        board_joy2  = '0;
        board_joy3  = '0;
        board_joy4  = '0;
        en4way      = 1'b0;
        rot_control = 1'b0;
        dip_flip    = 1'b0;
        downloading = 1'b0;
        osd_pause   = 1'b0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        seed        = 32'hdff4_6e54;
        load_table();

        wait_cycles(8);
        rst <= 1'b0;
        settle(1);
        check(32'(game_joy1), 32'h3FF, "reset game_joy1");
        check(32'(game_joy2), 32'h3FF, "reset game_joy2");
        check(32'(game_joy3), 32'h3FF, "reset game_joy3");
        check(32'(game_joy4), 32'h3FF, "reset game_joy4");
        check(32'({game_coin, game_start}), 32'hFF, "reset coin and start");
        check(32'(game_service), 32'h1, "reset game_service");
        check(32'(game_pause), 32'h0, "reset game_pause");
        check(32'(gfx_en), 32'hF, "reset gfx_en");

        for (i = 0; i < NROWS; i++) begin
            apply_row(rows[i]);
            settle(3);
            compare_row(rows[i], $sformatf("row %0d", i));
        end

        // random words with the pause bit cleared so game_pause is left alone
        for (i = 0; i < NRAND; i++) begin
            rnd = $random(seed);
            r.en4way = 1'b0;
            r.rot = rnd[0];
            r.flip = rnd[1];
            for (p = 0; p < 4; p++) begin
                r.joy[p] = 16'($random(seed)) & 16'hFEFF;
                r.exp_joy[p] = expect_joy(r.joy[p], r.rot, r.flip);
                r.exp_coin[p] = ~r.joy[p][7];
                r.exp_start[p] = ~r.joy[p][6];
            end
            apply_row(r);
            settle(3);
            compare_row(r, $sformatf("random %0d", i));
        end

        @(posedge clk_sys);
        board_joy1 <= '0;
        board_joy2 <= '0;
        board_joy3 <= '0;
        board_joy4 <= '0;
        @(posedge clk_sys);
        key_pause <= 1'b1;
        @(posedge clk_sys);
        key_pause <= 1'b0;
        wait_pause(1'b1, "key_pause pulse");
        @(posedge clk_sys);
        board_joy2 <= 16'h0100;
        @(posedge clk_sys);
        board_joy2 <= '0;
        wait_pause(1'b0, "player 2 pause button");
        @(posedge clk_sys);
        osd_pause <= 1'b1;
        wait_pause(1'b1, "osd_pause rising");
        @(posedge clk_sys);
        downloading <= 1'b1;
        wait_pause(1'b0, "downloading high");
        @(posedge clk_sys);
        downloading <= 1'b0;
        osd_pause   <= 1'b0;
        settle(2);
        check(32'(game_pause), 32'h0, "game_pause after download");

        // held key gives a single pulse
        @(posedge clk_sys);
        key_reset <= 1'b1;
        pulses = 0;
        for (i = 0; i < 12; i++) begin
            @(negedge clk_sys);
            if (soft_rst) begin
                pulses++;
            end
        end
        @(posedge clk_sys);
        key_reset <= 1'b0;
        check(32'(pulses), 32'h1, "soft_rst high cycles");

        @(posedge clk_sys);
        key_gfx <= 4'b0100;
        @(posedge clk_sys);
        key_gfx <= 4'b0000;
        settle(2);
        check(32'(gfx_en), 32'hB, "gfx_en after key_gfx bit 2");

        @(posedge clk_sys);
        key_service <= 1'b1;
        settle(2);
        check(32'(game_service), 32'h0, "game_service with key held");
        @(posedge clk_sys);
        key_service <= 1'b0;
        settle(2);
        check(32'(game_service), 32'h1, "game_service released");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/board_ctrl.sv ====
/*
 * frame control from edges of keys and buttons
 * game pause toggle with OSD override, soft reset pulse
 * per-layer graphics enable toggles
 */
module board_ctrl #(
    parameter int BUTTONS = 2
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              downloading,
    input  logic                              osd_pause,
    input  logic                              key_pause,
    input  logic                              key_reset,
    input  logic [input_pkg::GFX_W-1:0]       key_gfx,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word1,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word2,
    output logic                              game_pause,
    output logic                              soft_rst,
    output logic [input_pkg::GFX_W-1:0]       gfx_en
);

    localparam int PAUSE_BIT = input_pkg::PAUSE_OFS + BUTTONS - 2;

    logic                        joy_pause;
    logic                        last_key_pause;
    logic                        last_joy_pause;
    logic                        last_osd_pause;
    logic                        last_key_reset;
    logic [input_pkg::GFX_W-1:0] last_key_gfx;
    logic                        pause_toggle;
    logic                        osd_change;

    // either of the first two players can pause
    assign joy_pause = joy_word1[PAUSE_BIT] | joy_word2[PAUSE_BIT];

    // simultaneous edges still give a single toggle
    assign pause_toggle = (key_pause && !last_key_pause) ||
                          (joy_pause && !last_joy_pause);
    assign osd_change   = osd_pause ^ last_osd_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_key_reset <= 1'b0;
            last_key_gfx   <= '0;
            game_pause     <= 1'b0;
            soft_rst       <= 1'b0;
            gfx_en         <= '1;
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= osd_pause;
            last_key_reset <= key_reset;
            last_key_gfx   <= key_gfx;

            soft_rst <= key_reset && !last_key_reset;

            for (int i = 0; i < input_pkg::GFX_W; i++) begin
                if (key_gfx[i] && !last_key_gfx[i]) begin
                    gfx_en[i] <= ~gfx_en[i];
                end
            end

            // loading a ROM never runs paused
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                game_pause <= osd_pause;
            end else if (pause_toggle) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// ==== verilog/input_board.sv ====
/*
 * player-input section of the board frame
 * four 4-way filter stages feeding the output map stage
 * control block for pause, soft reset and layer enables
 */
module input_board #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic [input_pkg::BOARD_JOY_W-1:0] board_joy1,
    input  logic [input_pkg::BOARD_JOY_W-1:0] board_joy2,
    input  logic [input_pkg::BOARD_JOY_W-1:0] board_joy3,
    input  logic [input_pkg::BOARD_JOY_W-1:0] board_joy4,
    input  logic                              en4way,
    input  logic                              rot_control,
    input  logic                              dip_flip,
    input  logic                              downloading,
    input  logic                              osd_pause,
    input  logic                              key_pause,
    input  logic                              key_reset,
    input  logic                              key_service,
    input  logic [input_pkg::GFX_W-1:0]       key_gfx,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy1,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy2,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy3,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy4,
    output logic [input_pkg::PLAYERS-1:0]     game_coin,
    output logic [input_pkg::PLAYERS-1:0]     game_start,
    output logic                              game_service,
    output logic                              game_pause,
    output logic                              soft_rst,
    output logic [input_pkg::GFX_W-1:0]       gfx_en
);

    logic [input_pkg::BOARD_JOY_W-1:0] joy_word1;
    logic [input_pkg::BOARD_JOY_W-1:0] joy_word2;
    logic [input_pkg::BOARD_JOY_W-1:0] joy_word3;
    logic [input_pkg::BOARD_JOY_W-1:0] joy_word4;

    // stage 1 has one filter per player
    joy_4way_filter u_filt1 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en4way    (en4way),
        .board_joy (board_joy1),
        .joy_word  (joy_word1)
    );

    joy_4way_filter u_filt2 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en4way    (en4way),
        .board_joy (board_joy2),
        .joy_word  (joy_word2)
    );

    joy_4way_filter u_filt3 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en4way    (en4way),
        .board_joy (board_joy3),
        .joy_word  (joy_word3)
    );

    joy_4way_filter u_filt4 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en4way    (en4way),
        .board_joy (board_joy4),
        .joy_word  (joy_word4)
    );

    // stage 2 drives the game-facing outputs
    joy_map_stage #(
        .BUTTONS    (BUTTONS),
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_map (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .rot_control  (rot_control),
        .dip_flip     (dip_flip),
        .key_service  (key_service),
        .joy_word1    (joy_word1),
        .joy_word2    (joy_word2),
        .joy_word3    (joy_word3),
        .joy_word4    (joy_word4),
        .game_joy1    (game_joy1),
        .game_joy2    (game_joy2),
        .game_joy3    (game_joy3),
        .game_joy4    (game_joy4),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service)
    );

    board_ctrl #(
        .BUTTONS (BUTTONS)
    ) u_ctrl (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .osd_pause   (osd_pause),
        .key_pause   (key_pause),
        .key_reset   (key_reset),
        .key_gfx     (key_gfx),
        .joy_word1   (joy_word1),
        .joy_word2   (joy_word2),
        .game_pause  (game_pause),
        .soft_rst    (soft_rst),
        .gfx_en      (gfx_en)
    );

endmodule

// ==== verilog/input_pkg.sv ====
/*
 * shared widths and counts for the player-input pipeline
 * board word layout: directions, fire buttons, start, coin, pause
 * button offsets assume two fire buttons
 */
package input_pkg;

    // raw board joystick word with active-high bits
    localparam int BOARD_JOY_W = 16;

    // joystick word as seen by the game core
    localparam int GAME_JOY_W  = 10;

    // up/down/left/right in the low bits of both words
    localparam int DIR_W       = 4;

    localparam int PLAYERS     = 4;

    // graphics layers with a debug enable
    localparam int GFX_W       = 4;

    // base positions with two fire buttons
    // each shifts up by BUTTONS-2
    localparam int START_OFS   = 6;
    localparam int COIN_OFS    = 7;
    localparam int PAUSE_OFS   = 8;

endpackage

// ==== verilog/joy_4way_filter.sv ====
/*
 * joystick sync register with optional 4-way restriction
 * diagonals hold the last single direction while 4-way is on
 * button bits are registered unchanged
 */
module joy_4way_filter (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              en4way,
    input  logic [input_pkg::BOARD_JOY_W-1:0] board_joy,
    output logic [input_pkg::BOARD_JOY_W-1:0] joy_word
);

    localparam int DW = input_pkg::DIR_W;
    localparam int BW = input_pkg::BOARD_JOY_W;

    logic [DW-1:0] dir_in;
    logic [DW-1:0] dir_next;
    logic          dir_none;
    logic          dir_single;

    assign dir_in = board_joy[DW-1:0];

    // exactly one bit set when clearing the lowest set bit leaves zero
    assign dir_none   = (dir_in == '0);
    assign dir_single = !dir_none && ((dir_in & (dir_in - DW'(1))) == '0);

    always_comb begin
        if (!en4way) begin
            dir_next = dir_in;
        end else if (dir_single) begin
            dir_next = dir_in;
        end else if (dir_none) begin
            dir_next = '0;
        end else begin
            // diagonal keeps what was last sent
            dir_next = joy_word[DW-1:0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_word <= '0;
        end else begin
            joy_word <= {board_joy[BW-1:DW], dir_next};
        end
    end

endmodule

// ==== verilog/joy_map_stage.sv ====
/*
 * output register stage for the game inputs
 * rotation and flip of the direction bits
 * coin/start collection across players, service key
 * optional active-low inversion of everything
 */
module joy_map_stage #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              rot_control,
    input  logic                              dip_flip,
    input  logic                              key_service,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word1,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word2,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word3,
    input  logic [input_pkg::BOARD_JOY_W-1:0] joy_word4,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy1,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy2,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy3,
    output logic [input_pkg::GAME_JOY_W-1:0]  game_joy4,
    output logic [input_pkg::PLAYERS-1:0]     game_coin,
    output logic [input_pkg::PLAYERS-1:0]     game_start,
    output logic                              game_service
);

    localparam int GW        = input_pkg::GAME_JOY_W;
    localparam int NP        = input_pkg::PLAYERS;
    localparam int START_BIT = input_pkg::START_OFS + BUTTONS - 2;
    localparam int COIN_BIT  = input_pkg::COIN_OFS + BUTTONS - 2;

    logic [input_pkg::BOARD_JOY_W-1:0] words [NP];
    logic [NP-1:0]                     coin_raw;
    logic [NP-1:0]                     start_raw;

    // direction remap for vertical games on a horizontal screen
    function automatic logic [GW-1:0] rotate_joy(
        input logic [GW-1:0] joy,
        input logic          rot,
        input logic          flip
    );
        logic [GW-1:0] res;
        if (!rot) begin
            res = joy;
        end else if (!flip) begin
            res = {joy[GW-1:4], joy[1], joy[0], joy[2], joy[3]};
        end else begin
            res = {joy[GW-1:4], joy[0], joy[1], joy[3], joy[2]};
        end
        return res;
    endfunction

    assign words[0] = joy_word1;
    assign words[1] = joy_word2;
    assign words[2] = joy_word3;
    assign words[3] = joy_word4;

    // player 1 lands in bit 0
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            coin_raw[p]  = words[p][COIN_BIT];
            start_raw[p] = words[p][START_BIT];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy1    <= {GW{ACTIVE_LOW}};
            game_joy2    <= {GW{ACTIVE_LOW}};
            game_joy3    <= {GW{ACTIVE_LOW}};
            game_joy4    <= {GW{ACTIVE_LOW}};
            game_coin    <= {NP{ACTIVE_LOW}};
            game_start   <= {NP{ACTIVE_LOW}};
            game_service <= ACTIVE_LOW;
        end else begin
            game_joy1    <= {GW{ACTIVE_LOW}} ^
                            rotate_joy(joy_word1[GW-1:0], rot_control, dip_flip);
            game_joy2    <= {GW{ACTIVE_LOW}} ^
                            rotate_joy(joy_word2[GW-1:0], rot_control, dip_flip);
            game_joy3    <= {GW{ACTIVE_LOW}} ^
                            rotate_joy(joy_word3[GW-1:0], rot_control, dip_flip);
            game_joy4    <= {GW{ACTIVE_LOW}} ^
                            rotate_joy(joy_word4[GW-1:0], rot_control, dip_flip);
            game_coin    <= {NP{ACTIVE_LOW}} ^ coin_raw;
            game_start   <= {NP{ACTIVE_LOW}} ^ start_raw;
            game_service <= ACTIVE_LOW ^ key_service;
        end
    end

endmodule
